/* rtl/decodePkg.sv */
`default_nettype none

package decodePkg;

  localparam int DataWidth = 16;
  localparam int RegCount = 8;
  localparam int RegIdxWidth = 3;

  typedef logic [DataWidth-1:0] word_t;
  typedef logic [RegIdxWidth-1:0] regIdx_t;
  typedef logic [4:0] opcode_t;
  typedef logic [1:0] func_t;
  typedef logic [1:0] resultSel_t;
  typedef logic [1:0] immSel_t;

  // saved PC lives here, RTI returns through it
  localparam regIdx_t LinkReg = 3'd7;

  // opcode groups, taken from opcode bits 4:2
  localparam logic [2:0] GrpSys = 3'b000;
  localparam logic [2:0] GrpJump = 3'b001;
  localparam logic [2:0] GrpImm5 = 3'b010;
  localparam logic [2:0] GrpBranch = 3'b011;
  localparam logic [2:0] GrpMem = 3'b100;
  localparam logic [2:0] GrpShift = 3'b101;
  // register-register ops only need bits 4:3
  localparam logic [1:0] GrpReg = 2'b11;

  // low two opcode bits inside the system group
  localparam logic [1:0] SysHalt = 2'b00;
  localparam logic [1:0] SysNop = 2'b01;
  localparam logic [1:0] SysSiic = 2'b10;
  localparam logic [1:0] SysRti = 2'b11;

  // low two opcode bits inside the memory group
  localparam logic [1:0] MemStore = 2'b00;
  localparam logic [1:0] MemLoad = 2'b01;
  localparam logic [1:0] MemLbi = 2'b10;
  localparam logic [1:0] MemStu = 2'b11;

  // immediate formats
  localparam immSel_t ImmNone = 2'b00;
  localparam immSel_t Imm5 = 2'b01;
  localparam immSel_t Imm8 = 2'b10;
  localparam immSel_t Imm11 = 2'b11;

  // write-back result sources
  localparam resultSel_t ResAlu = 2'b00;
  localparam resultSel_t ResMem = 2'b01;
  localparam resultSel_t ResImm = 2'b10;
  localparam resultSel_t ResPc = 2'b11;

endpackage

`default_nettype wire

/* rtl/ctrlBus.sv */
`timescale 1ns/1ps
`default_nettype none

interface ctrlBus;
  import decodePkg::*;

  opcode_t opcode;
  func_t func;
  regIdx_t rd;
  immSel_t immSel;
  logic zeroExt;
  resultSel_t resultSel;
  logic regWrite;
  logic memRead;
  logic memWrite;
  logic memToReg;
  logic branch;
  logic jump;
  logic jr;
  logic halt;
  logic nop;
  logic savePC;
  logic rti;
  logic siic;

  modport decoder (
    output opcode, func, rd, immSel, zeroExt, resultSel,
    output regWrite, memRead, memWrite, memToReg, branch, jump, jr,
    output halt, nop, savePC, rti, siic
  );

  modport issue (
    input opcode, func, rd, immSel, zeroExt, resultSel,
    input regWrite, memRead, memWrite, memToReg, branch, jump, jr,
    input halt, nop, savePC, rti, siic
  );

endinterface

`default_nettype wire

/* rtl/ctrlDecoder.sv */
`timescale 1ns/1ps
`default_nettype none

module ctrlDecoder (
  input  decodePkg::word_t   instr,
  ctrlBus.decoder            ctrl,
  output decodePkg::regIdx_t rs,
  output decodePkg::regIdx_t rt
);
  import decodePkg::*;

  opcode_t opcode;

  assign opcode = instr[15:11];
  assign ctrl.opcode = opcode;
  assign ctrl.func = instr[1:0];

  // RTI jumps back through the link register
  assign rs = (opcode == {GrpSys, SysRti}) ? LinkReg : instr[10:8];
  assign rt = instr[7:5];

  always_comb begin
    ctrl.rd = instr[7:5];
    ctrl.immSel = ImmNone;
    ctrl.zeroExt = 1'b0;
    ctrl.resultSel = ResAlu;
    ctrl.regWrite = 1'b0;
    ctrl.memRead = 1'b0;
    ctrl.memWrite = 1'b0;
    ctrl.memToReg = 1'b0;
    ctrl.branch = 1'b0;
    ctrl.jump = 1'b0;
    ctrl.jr = 1'b0;
    ctrl.halt = 1'b0;
    ctrl.nop = 1'b0;
    ctrl.savePC = 1'b0;
    ctrl.rti = 1'b0;
    ctrl.siic = 1'b0;

    if (opcode[4:3] == GrpReg) begin
      // three-register form, destination in the low field
      ctrl.regWrite = 1'b1;
      ctrl.rd = instr[4:2];
    end else begin
      case (opcode[4:2])
        GrpSys: begin
          case (opcode[1:0])
            SysHalt: ctrl.halt = 1'b1;
            SysNop:  ctrl.nop = 1'b1;
            SysSiic: begin
              ctrl.siic = 1'b1;
              ctrl.savePC = 1'b1;
              ctrl.rd = LinkReg;
            end
            default: ctrl.rti = 1'b1;
          endcase
        end
        GrpJump: begin
          // bit 11 register-indirect, bit 12 link
          ctrl.jump = 1'b1;
          ctrl.jr = opcode[0];
          ctrl.immSel = opcode[0] ? Imm8 : Imm11;
          if (opcode[1]) begin
            ctrl.savePC = 1'b1;
            ctrl.regWrite = 1'b1;
            ctrl.rd = LinkReg;
            ctrl.resultSel = ResPc;
          end
        end
        GrpImm5: begin
          ctrl.regWrite = 1'b1;
          ctrl.immSel = Imm5;
          // logic ops take the field unsigned
          ctrl.zeroExt = opcode[1];
        end
        GrpBranch: begin
          ctrl.branch = 1'b1;
          ctrl.immSel = Imm8;
        end
        GrpMem: begin
          ctrl.immSel = Imm5;
          case (opcode[1:0])
            MemStore: ctrl.memWrite = 1'b1;
            MemLoad: begin
              ctrl.memRead = 1'b1;
              ctrl.memToReg = 1'b1;
              ctrl.regWrite = 1'b1;
              ctrl.resultSel = ResMem;
            end
            MemLbi: begin
              ctrl.regWrite = 1'b1;
              ctrl.immSel = Imm8;
              ctrl.zeroExt = 1'b1;
              ctrl.rd = instr[10:8];
              ctrl.resultSel = ResImm;
            end
            default: begin
              // store-and-update writes the new address back to rs
              ctrl.memWrite = 1'b1;
              ctrl.regWrite = 1'b1;
              ctrl.rd = instr[10:8];
            end
          endcase
        end
        GrpShift: begin
          ctrl.regWrite = 1'b1;
          ctrl.immSel = Imm5;
        end
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

/* rtl/operandFetch.sv */
`timescale 1ns/1ps
`default_nettype none

module operandFetch (
  input  logic               clk,
  input  logic               reset,
  input  decodePkg::regIdx_t rs,
  input  decodePkg::regIdx_t rt,
  input  logic               wbEn,
  input  decodePkg::regIdx_t wbReg,
  input  decodePkg::word_t   wbData,
  output decodePkg::word_t   rsVal,
  output decodePkg::word_t   rtVal
);
  import decodePkg::*;

  word_t regs [RegCount];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < RegCount; i++) begin
        regs[i] <= '0;
      end
    end else if (wbEn) begin
      regs[wbReg] <= wbData;
    end
  end

  // no bypass, a same-cycle write shows up next cycle
  assign rsVal = regs[rs];
  assign rtVal = regs[rt];

endmodule

`default_nettype wire

/* rtl/decodeIssue.sv */
`timescale 1ns/1ps
`default_nettype none

module decodeIssue #(
  parameter int QueueDepth = 2,
  parameter int OutCredits = 4
) (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   instrValid,
  input  decodePkg::word_t       instr,
  ctrlBus.issue                  ctrl,
  input  decodePkg::word_t       rsVal,
  input  decodePkg::word_t       rtVal,
  output logic                   instrCredit,
  input  logic                   outCredit,
  output logic                   outValid,
  output decodePkg::opcode_t     outOpcode,
  output decodePkg::func_t       outFunc,
  output decodePkg::regIdx_t     outRd,
  output decodePkg::word_t       outRsVal,
  output decodePkg::word_t       outRtVal,
  output decodePkg::word_t       outImm,
  output decodePkg::resultSel_t  outResultSel,
  output logic                   outRegWrite,
  output logic                   outMemRead,
  output logic                   outMemWrite,
  output logic                   outMemToReg,
  output logic                   outBranch,
  output logic                   outJump,
  output logic                   outJr,
  output logic                   outHalt,
  output logic                   outNop,
  output logic                   outSavePC,
  output logic                   outRti,
  output logic                   outSiic
);
  import decodePkg::*;

  localparam int FlagCount = 12;
  localparam int UopWidth = $bits(opcode_t) + $bits(func_t) + $bits(regIdx_t) +
                            3 * DataWidth + $bits(resultSel_t) + FlagCount;
  localparam int PtrWidth = (QueueDepth > 1) ? $clog2(QueueDepth) : 1;
  localparam int CountWidth = $clog2(QueueDepth + 1);
  localparam int CreditWidth = $clog2(OutCredits + 1);

  logic [UopWidth-1:0] queue [QueueDepth];
  logic [UopWidth-1:0] uopIn;
  logic [PtrWidth-1:0] wrPtr;
  logic [PtrWidth-1:0] rdPtr;
  logic [CountWidth-1:0] count;
  logic [CreditWidth-1:0] creditCnt;
  word_t imm;
  logic push;
  logic pop;

  always_comb begin
    case (ctrl.immSel)
      Imm5:    imm = ctrl.zeroExt ? word_t'(instr[4:0]) :
                     {{(DataWidth-5){instr[4]}}, instr[4:0]};
      Imm8:    imm = ctrl.zeroExt ? word_t'(instr[7:0]) :
                     {{(DataWidth-8){instr[7]}}, instr[7:0]};
      Imm11:   imm = ctrl.zeroExt ? word_t'(instr[10:0]) :
                     {{(DataWidth-11){instr[10]}}, instr[10:0]};
      default: imm = '0;
    endcase
  end

  assign uopIn = {ctrl.opcode, ctrl.func, ctrl.rd, rsVal, rtVal, imm, ctrl.resultSel,
                  ctrl.regWrite, ctrl.memRead, ctrl.memWrite, ctrl.memToReg,
                  ctrl.branch, ctrl.jump, ctrl.jr, ctrl.halt, ctrl.nop,
                  ctrl.savePC, ctrl.rti, ctrl.siic};

  // fetch only sends while it holds a credit, so a push never finds the queue full
  assign push = instrValid;
  assign pop = (count != '0) && (creditCnt != '0);

  assign outValid = pop;
  assign instrCredit = pop;

  assign {outOpcode, outFunc, outRd, outRsVal, outRtVal, outImm, outResultSel,
          outRegWrite, outMemRead, outMemWrite, outMemToReg,
          outBranch, outJump, outJr, outHalt, outNop,
          outSavePC, outRti, outSiic} = queue[rdPtr];

  always_ff @(posedge clk) begin
    if (push) begin
      queue[wrPtr] <= uopIn;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (push) begin
        wrPtr <= (wrPtr == PtrWidth'(QueueDepth - 1)) ? '0 : wrPtr + 1'b1;
      end
      if (pop) begin
        rdPtr <= (rdPtr == PtrWidth'(QueueDepth - 1)) ? '0 : rdPtr + 1'b1;
      end
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  // execute-side slots, a return and a send together cancel out
  always_ff @(posedge clk) begin
    if (reset) begin
      creditCnt <= CreditWidth'(OutCredits);
    end else if (outCredit && !pop) begin
      creditCnt <= creditCnt + 1'b1;
    end else if (pop && !outCredit) begin
      creditCnt <= creditCnt - 1'b1;
    end
  end

endmodule

`default_nettype wire

/* rtl/decodeStage.sv */
`timescale 1ns/1ps
`default_nettype none

module decodeStage #(
  parameter int QueueDepth = 2,
  parameter int OutCredits = 4
) (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   instrValid,
  input  decodePkg::word_t       instr,
  output logic                   instrCredit,
  input  logic                   outCredit,
  output logic                   outValid,
  output decodePkg::opcode_t     outOpcode,
  output decodePkg::func_t       outFunc,
  output decodePkg::regIdx_t     outRd,
  output decodePkg::word_t       outRsVal,
  output decodePkg::word_t       outRtVal,
  output decodePkg::word_t       outImm,
  output decodePkg::resultSel_t  outResultSel,
  output logic                   outRegWrite,
  output logic                   outMemRead,
  output logic                   outMemWrite,
  output logic                   outMemToReg,
  output logic                   outBranch,
  output logic                   outJump,
  output logic                   outJr,
  output logic                   outHalt,
  output logic                   outNop,
  output logic                   outSavePC,
  output logic                   outRti,
  output logic                   outSiic,
  input  logic                   wbEn,
  input  decodePkg::regIdx_t     wbReg,
  input  decodePkg::word_t       wbData
);
  import decodePkg::*;

  regIdx_t rs;
  regIdx_t rt;
  word_t rsVal;
  word_t rtVal;

  ctrlBus ctrl ();

  ctrlDecoder decoder_i (
    .instr (instr),
    .ctrl  (ctrl.decoder),
    .rs    (rs),
    .rt    (rt)
  );

  // register read runs alongside the decoder in the accept cycle
  operandFetch regFile_i (
    .clk    (clk),
    .reset  (reset),
    .rs     (rs),
    .rt     (rt),
    .wbEn   (wbEn),
    .wbReg  (wbReg),
    .wbData (wbData),
    .rsVal  (rsVal),
    .rtVal  (rtVal)
  );

  decodeIssue #(
    .QueueDepth (QueueDepth),
    .OutCredits (OutCredits)
  ) issue_i (
    .clk          (clk),
    .reset        (reset),
    .instrValid   (instrValid),
    .instr        (instr),
    .ctrl         (ctrl.issue),
    .rsVal        (rsVal),
    .rtVal        (rtVal),
    .instrCredit  (instrCredit),
    .outCredit    (outCredit),
    .outValid     (outValid),
    .outOpcode    (outOpcode),
    .outFunc      (outFunc),
    .outRd        (outRd),
    .outRsVal     (outRsVal),
    .outRtVal     (outRtVal),
    .outImm       (outImm),
    .outResultSel (outResultSel),
    .outRegWrite  (outRegWrite),
    .outMemRead   (outMemRead),
    .outMemWrite  (outMemWrite),
    .outMemToReg  (outMemToReg),
    .outBranch    (outBranch),
    .outJump      (outJump),
    .outJr        (outJr),
    .outHalt      (outHalt),
    .outNop       (outNop),
    .outSavePC    (outSavePC),
    .outRti       (outRti),
    .outSiic      (outSiic)
  );

endmodule

`default_nettype wire

/* dv/decodeStage_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module decodeStage_checker #(
  parameter int QueueDepth = 2,
  parameter int OutCredits = 4
) (
  input logic                              clk,
  input logic                              reset,
  input logic                              instrValid,
  input logic                              outCredit,
  input logic                              outValid,
  input logic                              instrCredit,
  input logic [$clog2(OutCredits+1)-1:0]   creditCnt,
  input logic [$clog2(QueueDepth+1)-1:0]   count
);

  int assertFails = 0;

  // spending the last slot with no return has to stop the next send
  sendNeedsCredit: assert property (
    @(posedge clk) disable iff (reset)
    (outValid && !outCredit && creditCnt == 1) |=> !outValid
  ) else begin
    $error("outValid raised with no execute credit left");
    assertFails++;
  end

  creditBound: assert property (
    @(posedge clk) disable iff (reset) creditCnt <= OutCredits
  ) else begin
    $error("execute credit count above its limit");
    assertFails++;
  end

  // fetch credit only comes back when a micro-op leaves
  creditOnPop: assert property (
    @(posedge clk) disable iff (reset)
    instrCredit |=> (count == $past(count) + $past(instrValid) - 1)
  ) else begin
    $error("instrCredit raised without a pop");
    assertFails++;
  end

endmodule

bind decodeIssue decodeStage_checker #(
  .QueueDepth (QueueDepth),
  .OutCredits (OutCredits)
) checker_i (
  .clk         (clk),
  .reset       (reset),
  .instrValid  (instrValid),
  .outCredit   (outCredit),
  .outValid    (outValid),
  .instrCredit (instrCredit),
  .creditCnt   (creditCnt),
  .count       (count)
);

`default_nettype wire

/* dv/decodeScoreboard.sv */
`timescale 1ns/1ps
`default_nettype none

module decodeScoreboard (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   instrValid,
  input  decodePkg::word_t       instr,
  input  logic                   wbEn,
  input  decodePkg::regIdx_t     wbReg,
  input  decodePkg::word_t       wbData,
  input  logic                   outValid,
  input  decodePkg::opcode_t     outOpcode,
  input  decodePkg::func_t       outFunc,
  input  decodePkg::regIdx_t     outRd,
  input  decodePkg::word_t       outRsVal,
  input  decodePkg::word_t       outRtVal,
  input  decodePkg::word_t       outImm,
  input  decodePkg::resultSel_t  outResultSel,
  input  logic [11:0]            outFlags,
  output int                     errorCount,
  output int                     pending
);
  import decodePkg::*;

  // flag positions, regWrite down to siic
  localparam int FRegWrite = 11;
  localparam int FMemRead = 10;
  localparam int FMemWrite = 9;
  localparam int FMemToReg = 8;
  localparam int FBranch = 7;
  localparam int FJump = 6;
  localparam int FJr = 5;
  localparam int FHalt = 4;
  localparam int FNop = 3;
  localparam int FSavePC = 2;
  localparam int FRti = 1;
  localparam int FSiic = 0;

  typedef struct packed {
    opcode_t opcode;
    func_t func;
    regIdx_t rd;
    word_t rsVal;
    word_t rtVal;
    word_t imm;
    resultSel_t resultSel;
    logic [11:0] flags;
  } uop_t;

  word_t shadow [8];
  uop_t expQ [$];
  uop_t expUop;

  function automatic uop_t refDecode(input word_t ins);
    uop_t u;
    logic [4:0] op;
    immSel_t fmt;
    logic zext;
    regIdx_t rsIdx;
    op = ins[15:11];
    u = '0;
    u.opcode = op;
    u.func = ins[1:0];
    u.rd = ins[7:5];
    fmt = ImmNone;
    zext = 1'b0;
    casez (op)
      5'b00000: u.flags[FHalt] = 1'b1;
      5'b00001: u.flags[FNop] = 1'b1;
      5'b00010: begin
        u.flags[FSiic] = 1'b1;
        u.flags[FSavePC] = 1'b1;
        u.rd = 3'd7;
      end
      5'b00011: u.flags[FRti] = 1'b1;
      5'b001??: begin
        u.flags[FJump] = 1'b1;
        u.flags[FJr] = op[0];
        fmt = op[0] ? Imm8 : Imm11;
        // linking jumps save the PC in r7
        if (op[1]) begin
          u.flags[FSavePC] = 1'b1;
          u.flags[FRegWrite] = 1'b1;
          u.rd = 3'd7;
          u.resultSel = ResPc;
        end
      end
      5'b010??: begin
        u.flags[FRegWrite] = 1'b1;
        fmt = Imm5;
        zext = op[1];
      end
      5'b011??: begin
        u.flags[FBranch] = 1'b1;
        fmt = Imm8;
      end
      5'b10000: begin
        u.flags[FMemWrite] = 1'b1;
        fmt = Imm5;
      end
      5'b10001: begin
        u.flags[FMemRead] = 1'b1;
        u.flags[FMemToReg] = 1'b1;
        u.flags[FRegWrite] = 1'b1;
        u.resultSel = ResMem;
        fmt = Imm5;
      end
      5'b10010: begin
        u.flags[FRegWrite] = 1'b1;
        fmt = Imm8;
        zext = 1'b1;
        u.rd = ins[10:8];
        u.resultSel = ResImm;
      end
      5'b10011: begin
        u.flags[FMemWrite] = 1'b1;
        u.flags[FRegWrite] = 1'b1;
        u.rd = ins[10:8];
        fmt = Imm5;
      end
      5'b101??: begin
        u.flags[FRegWrite] = 1'b1;
        fmt = Imm5;
      end
      default: begin
        u.flags[FRegWrite] = 1'b1;
        u.rd = ins[4:2];
      end
    endcase
    case (fmt)
      Imm5: u.imm = zext ? {11'b0, ins[4:0]} : {{11{ins[4]}}, ins[4:0]};
      Imm8: u.imm = zext ? {8'b0, ins[7:0]} : {{8{ins[7]}}, ins[7:0]};
      Imm11: u.imm = zext ? {5'b0, ins[10:0]} : {{5{ins[10]}}, ins[10:0]};
      default: u.imm = '0;
    endcase
    rsIdx = (op == 5'b00011) ? 3'd7 : ins[10:8];
    u.rsVal = shadow[rsIdx];
    u.rtVal = shadow[ins[7:5]];
    return u;
  endfunction

  task automatic checkField(input string name, input logic [15:0] expV,
                            input logic [15:0] actV);
    if (expV !== actV) begin
      $display("error at %0t: %s expected %h, got %h", $time, name, expV, actV);
      errorCount++;
    end
  endtask

  initial begin
    errorCount = 0;
    pending = 0;
  end

  always @(posedge clk) begin
    if (reset) begin
      expQ.delete();
      for (int i = 0; i < 8; i++) begin
        shadow[i] = '0;
      end
    end else begin
      if (outValid) begin
        if (expQ.size() == 0) begin
          $display("error at %0t: outValid with no micro-op expected", $time);
          errorCount++;
        end else begin
          expUop = expQ.pop_front();
          checkField("opcode", expUop.opcode, outOpcode);
          checkField("func", expUop.func, outFunc);
          checkField("rd", expUop.rd, outRd);
          checkField("rsVal", expUop.rsVal, outRsVal);
          checkField("rtVal", expUop.rtVal, outRtVal);
          checkField("imm", expUop.imm, outImm);
          checkField("resultSel", expUop.resultSel, outResultSel);
          checkField("flags", expUop.flags, outFlags);
        end
      end
      // decode sees the register file before this edge's write
      if (instrValid) begin
        expQ.push_back(refDecode(instr));
      end
      if (wbEn) begin
        shadow[wbReg] = wbData;
      end
    end
    pending = expQ.size();
  end

endmodule

`default_nettype wire

/* dv/decodeStage_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module decodeStage_tb;
  import decodePkg::*;

  localparam int QueueDepth = 2;
  localparam int OutCredits = 4;
  localparam int RandomCount = 300;
  localparam int TotalInstr = 32 + 7 + 9 + 4 + (OutCredits + QueueDepth) + RandomCount;
  localparam int CycleLimit = 4 * TotalInstr + 200;

  logic clk;
  logic reset;
  logic instrValid;
  word_t instr;
  logic instrCredit;
  logic outCredit;
  logic outValid;
  opcode_t outOpcode;
  func_t outFunc;
  regIdx_t outRd;
  word_t outRsVal;
  word_t outRtVal;
  word_t outImm;
  resultSel_t outResultSel;
  logic [11:0] outFlags;
  logic wbEn;
  regIdx_t wbReg;
  word_t wbData;
  int errorCount;
  int pending;

  integer seed = 29203;
  int cycles = 0;
  int sent = 0;
  int outBeats = 0;
  int fetchReturned = 0;
  int execReturned = 0;
  int passCount = 0;
  int failCount = 0;
  int errBefore = 0;
  int startBeats;
  int startReturned;
  int stallRoll = 0;
  bit holdCredits = 1'b0;
  bit randomStalls = 1'b0;
  bit bpOk;
  word_t randInstr;
  logic randWb;

  decodeStage #(
    .QueueDepth (QueueDepth),
    .OutCredits (OutCredits)
  ) dut_i (
    .clk (clk), .reset (reset), .instrValid (instrValid), .instr (instr),
    .instrCredit (instrCredit), .outCredit (outCredit), .outValid (outValid),
    .outOpcode (outOpcode), .outFunc (outFunc), .outRd (outRd),
    .outRsVal (outRsVal), .outRtVal (outRtVal), .outImm (outImm),
    .outResultSel (outResultSel), .outRegWrite (outFlags[11]),
    .outMemRead (outFlags[10]), .outMemWrite (outFlags[9]), .outMemToReg (outFlags[8]),
    .outBranch (outFlags[7]), .outJump (outFlags[6]), .outJr (outFlags[5]),
    .outHalt (outFlags[4]), .outNop (outFlags[3]), .outSavePC (outFlags[2]),
    .outRti (outFlags[1]), .outSiic (outFlags[0]),
    .wbEn (wbEn), .wbReg (wbReg), .wbData (wbData)
  );

  decodeScoreboard scoreboard_i (
    .clk (clk), .reset (reset), .instrValid (instrValid), .instr (instr),
    .wbEn (wbEn), .wbReg (wbReg), .wbData (wbData), .outValid (outValid),
    .outOpcode (outOpcode), .outFunc (outFunc), .outRd (outRd),
    .outRsVal (outRsVal), .outRtVal (outRtVal), .outImm (outImm),
    .outResultSel (outResultSel), .outFlags (outFlags),
    .errorCount (errorCount), .pending (pending)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
    // one draw per cycle keeps the stall sequence fixed
    stallRoll = $random(seed);
    if (outValid) outBeats++;
    if (instrCredit) fetchReturned++;
    if (cycles >= CycleLimit) begin
      $display("timeout: the run did not finish within %0d cycles", CycleLimit);
      $display(">>> FAIL");
      $finish;
    end
  end

  // execute stage, hands a slot back for each micro-op it got
  always @(negedge clk) begin
    outCredit = 1'b0;
    if (!reset && !holdCredits && outBeats > execReturned) begin
      if (!randomStalls || (stallRoll & 3) != 0) begin
        outCredit = 1'b1;
        execReturned++;
      end
    end
  end

  // scoreboard mismatches plus failed assertions in the bound checker
  function automatic int mismatchTotal();
    return errorCount + dut_i.issue_i.checker_i.assertFails;
  endfunction

  task automatic sendInstr(input word_t ins, input logic doWb, input regIdx_t wbIdx,
                           input word_t data);
    @(negedge clk);
    instrValid = 1'b0;
    wbEn = 1'b0;
    while (QueueDepth + fetchReturned - sent <= 0) @(negedge clk);
    instrValid = 1'b1;
    instr = ins;
    wbEn = doWb;
    wbReg = wbIdx;
    wbData = data;
    sent++;
  endtask

  task automatic writeReg(input regIdx_t wbIdx, input word_t data);
    @(negedge clk);
    instrValid = 1'b0;
    wbEn = 1'b1;
    wbReg = wbIdx;
    wbData = data;
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(negedge clk);
      instrValid = 1'b0;
      wbEn = 1'b0;
    end
  endtask

  task automatic drain;
    idle(1);
    while (pending != 0 || outBeats != execReturned) @(negedge clk);
    @(negedge clk);
  endtask

  task automatic finishTest(input string name, input bit extraOk);
    int errs;
    errs = mismatchTotal() - errBefore;
    if (errs == 0 && extraOk) begin
      passCount++;
      $display("test %s: ok", name);
    end else begin
      failCount++;
      $display("test %s: failed with %0d mismatches", name, errs);
    end
    errBefore = mismatchTotal();
  endtask

  initial begin
    reset = 1'b1;
    instrValid = 1'b0;
    instr = '0;
    outCredit = 1'b0;
    wbEn = 1'b0;
    wbReg = '0;
    wbData = '0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    // every opcode, so every group
    for (int op = 0; op < 32; op++) begin
      sendInstr({5'(op), 11'h2a5 + 11'(op * 97)}, 1'b0, '0, '0);
    end
    drain();
    finishTest("groups", 1'b1);

    sendInstr({5'b01000, 3'd1, 3'd2, 5'b10110}, 1'b0, '0, '0);
    sendInstr({5'b01010, 3'd1, 3'd2, 5'b10110}, 1'b0, '0, '0);
    sendInstr({5'b01100, 3'd1, 8'h95}, 1'b0, '0, '0);
    sendInstr({5'b10010, 3'd2, 8'hc3}, 1'b0, '0, '0);
    sendInstr({5'b00100, 11'h6a5}, 1'b0, '0, '0);
    sendInstr({5'b00111, 3'd3, 8'hf0}, 1'b0, '0, '0);
    sendInstr({5'b10001, 3'd1, 3'd2, 5'b11111}, 1'b0, '0, '0);
    drain();
    finishTest("immediates", 1'b1);

    for (int r = 1; r < 8; r++) begin
      writeReg(3'(r), 16'h1000 * 16'(r) + 16'h0a0 + 16'(r));
    end
    for (int r = 1; r < 8; r++) begin
      sendInstr({5'b11000, 3'(r), 3'(8 - r), 5'b00101}, 1'b0, '0, '0);
    end
    // same-cycle write to r3 must not be seen yet
    sendInstr({5'b11001, 3'd3, 3'd4, 5'b01000}, 1'b1, 3'd3, 16'hbeef);
    sendInstr({5'b11001, 3'd3, 3'd4, 5'b01000}, 1'b0, '0, '0);
    drain();
    finishTest("operands", 1'b1);

    sendInstr({5'b00011, 11'h000}, 1'b0, '0, '0);
    sendInstr({5'b00110, 11'h123}, 1'b0, '0, '0);
    sendInstr({5'b00111, 3'd2, 8'h10}, 1'b0, '0, '0);
    sendInstr({5'b00010, 11'h0e4}, 1'b0, '0, '0);
    drain();
    finishTest("link register", 1'b1);

    @(posedge clk);
    holdCredits = 1'b1;
    startBeats = outBeats;
    startReturned = fetchReturned;
    bpOk = 1'b1;
    for (int i = 0; i < OutCredits + QueueDepth; i++) begin
      sendInstr({5'b11010, 3'(i), 3'(i + 1), 5'(i)}, 1'b0, '0, '0);
    end
    idle(10);
    if (outBeats - startBeats != OutCredits) begin
      $display("error at %0t: %0d outputs with credits withheld, expected %0d",
               $time, outBeats - startBeats, OutCredits);
      bpOk = 1'b0;
    end
    @(posedge clk);
    holdCredits = 1'b0;
    drain();
    if (outBeats - startBeats != OutCredits + QueueDepth) begin
      $display("error at %0t: %0d outputs after credits returned, expected %0d",
               $time, outBeats - startBeats, OutCredits + QueueDepth);
      bpOk = 1'b0;
    end
    if (fetchReturned - startReturned != outBeats - startBeats) begin
      $display("error at %0t: %0d fetch credits for %0d outputs", $time,
               fetchReturned - startReturned, outBeats - startBeats);
      bpOk = 1'b0;
    end
    finishTest("back-pressure", bpOk);

    @(posedge clk);
    randomStalls = 1'b1;
    @(negedge clk);
    for (int i = 0; i < RandomCount; i++) begin
      if (($random(seed) & 3) == 0) idle(1);
      randInstr = $random(seed);
      randWb = (($random(seed) & 7) == 0);
      sendInstr(randInstr, randWb, 3'($random(seed)), 16'($random(seed)));
    end
    drain();
    randomStalls = 1'b0;
    finishTest("random stream", 1'b1);

    $display("tests passed: %0d, failed: %0d", passCount, failCount);
    if (failCount == 0 && mismatchTotal() == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* compile.f */
rtl/decodePkg.sv
rtl/ctrlBus.sv
rtl/ctrlDecoder.sv
rtl/operandFetch.sv
rtl/decodeIssue.sv
rtl/decodeStage.sv
dv/decodeStage_checker.sv
dv/decodeScoreboard.sv
dv/decodeStage_tb.sv

/* Bender.yml */
package:
  name: decode_stage

sources:
  - rtl/decodePkg.sv
  - rtl/ctrlBus.sv
  - rtl/ctrlDecoder.sv
  - rtl/operandFetch.sv
  - rtl/decodeIssue.sv
  - rtl/decodeStage.sv
  - target: test
    files:
      - dv/decodeStage_checker.sv
      - dv/decodeScoreboard.sv
      - dv/decodeStage_tb.sv
